// ==== vlog.f ====
hdl/bank_sched_pkg.sv
hdl/req_decode.sv
hdl/bank_queues.sv
hdl/burst_sched.sv
hdl/bank_sched_top.sv
testbench/bank_sched_assertions.sv
testbench/bank_sched_tb.sv

// ==== Makefile ====
# Verilator build and run of the bank scheduler testbench

obj_dir/Vbank_sched_tb: vlog.f hdl/*.sv testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module bank_sched_tb -f vlog.f

run: obj_dir/Vbank_sched_tb
	./obj_dir/Vbank_sched_tb | tee sim.log
	grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== testbench/bank_sched_tb.sv ====
`timescale 1ns/1ps

module bank_sched_tb;

   import bank_sched_pkg::*;

   localparam int TEST_CYCLES = 10 + 5 + 20 + 15 + 15 + 12 + 230; // Reset plus tests 1 to 6
   localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

   logic             clk;
   logic             rst_n_i;
   logic             req_valid_i;
   req_t             req_i;
   logic             mode_i;
   logic             ready_i;
   logic             req_stall_o;
   logic             result_valid_o;
   entry_t           result_o;

   entry_t           mq [Q_NUM][$];          // Model queues
   burst_t           m_last;                 // Model last served burst
   int               m_rr [2];               // Model pointers, indexed by mode
   logic             exp_valid;              // Model popped at the previous edge
   entry_t           exp_entry;              // Entry it popped
   logic [IDX_W-1:0] next_idx;
   int               errors = 0;
   int               checks = 0;
   int               tests  = 0;
   int               cycles = 0;
   int               seed;

   bank_sched_top uut (.*);

   initial clk = 1'b0;
   always #20 clk = ~clk;                    // 40 ns period

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, tests did not complete", cycles);
         $display("=== FAIL ===");
         $finish;
      end
   end

   task automatic compare_bit(string name, logic got, logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic compare_entry(string name, entry_t got, entry_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // Row and column with the four beat bits dropped
   function automatic burst_t burst_addr(entry_t e);
      return burst_t'({e.ra, e.ca} >> 4);
   endfunction

   function automatic entry_t to_entry(req_t r);
      entry_t e;
      e.idx      = r.idx;
      e.ra       = r.ra;
      e.ca       = r.ca;
      e.dq       = r.dq;
      e.req_type = r.req_type;
      return e;
   endfunction

   // Target queue of a request, -1 when it must stall
   function automatic int model_target(req_t r);
      if (r.req_type == READ) begin
         return (mq[r.ra[1:0]].size() < RD_Q_DEPTH) ? int'(r.ra[1:0]) : -1;
      end
      for (int q = RD_Q_NUM; q < Q_NUM; q++) begin
         if (mq[q].size() < WR_Q_DEPTH) begin
            return q;                        // Lowest write queue with room
         end
      end
      return -1;
   endfunction

   // Queue to pop this cycle, -1 for none
   function automatic int model_pick(logic mode, logic ready);
      int base;
      int num;
      int q;
      base = (mode == WRITE) ? RD_Q_NUM : 0;
      num  = (mode == WRITE) ? WR_Q_NUM : RD_Q_NUM;
      if (!ready) begin
         return -1;
      end
      for (q = base; q < base + num; q++) begin
         if (mq[q].size() > 0 && burst_addr(mq[q][0]) == m_last) begin
            return q;                        // Open burst wins
         end
      end
      for (int k = 1; k <= num; k++) begin
         q = base + (m_rr[mode] - base + k) % num;
         if (mq[q].size() > 0) begin
            return q;                        // First after the pointer
         end
      end
      return -1;
   endfunction

   function automatic int group_fill(int base, int num);
      int n;
      n = 0;
      for (int q = base; q < base + num; q++) begin
         n += mq[q].size();
      end
      return n;
   endfunction

   // One clock: drive, check at the falling edge, advance the model
   task automatic cycle(logic valid, req_t r, logic mode, logic ready);
      int tgt;
      int pick;
      req_valid_i = valid;
      req_i       = r;
      mode_i      = mode;
      ready_i     = ready;
      tgt  = valid ? model_target(r) : -2;
      pick = model_pick(mode, ready);
      @(negedge clk);
      compare_bit("req_stall_o", req_stall_o, tgt == -1);
      compare_bit("result_valid_o", result_valid_o, exp_valid);
      if (exp_valid && result_valid_o) begin
         compare_entry("result_o", result_o, exp_entry);
      end
      exp_valid = (pick >= 0);
      if (pick >= 0) begin
         exp_entry  = mq[pick].pop_front();
         m_last     = burst_addr(exp_entry);
         m_rr[mode] = pick;
      end
      if (tgt >= 0) begin
         mq[tgt].push_back(to_entry(r));     // Push sees fullness before the pop
      end
      @(posedge clk);
      #2;
   endtask

   task automatic send(logic t, logic [RA_W-1:0] ra, logic [CA_W-1:0] ca,
                       logic [DQ_W-1:0] dq, logic mode, logic ready);
      req_t r;
      r.req_type = t;
      r.idx      = next_idx;
      r.ra       = ra;
      r.ca       = ca;
      r.dq       = dq;
      next_idx++;
      cycle(1'b1, r, mode, ready);
   endtask

   task automatic idle(int n, logic mode, logic ready);
      repeat (n) cycle(1'b0, '0, mode, ready);
   endtask

   // Empty both groups, then one quiet cycle to check the last result
   task automatic drain();
      while (group_fill(0, RD_Q_NUM) > 0) begin
         cycle(1'b0, '0, READ, 1'b1);
      end
      while (group_fill(RD_Q_NUM, WR_Q_NUM) > 0) begin
         cycle(1'b0, '0, WRITE, 1'b1);
      end
      idle(1, READ, 1'b0);
   endtask

   task automatic end_test(string name);
      tests++;
      $display("Test %0d %s done, %0d errors so far", tests, name, errors);
   endtask

   task automatic test_reset();
      compare_bit("result_valid_o", result_valid_o, 1'b0);
      compare_bit("req_stall_o", req_stall_o, 1'b0);
      idle(4, READ, 1'b1);                   // Nothing queued, nothing served
      end_test("reset state");
   endtask

   task automatic test_read_order();
      for (int i = 0; i < 8; i++) begin     // Queues 0..2, entry 6 repeats burst of entry 0
         send(READ, RA_W'(16'h0100 + (i % 3) * 5), CA_W'((i % 2) * 16), '0, READ, 1'b0);
      end
      drain();
      end_test("read routing and order");
   endtask

   task automatic test_write_group();
      for (int i = 0; i < 4; i++) begin     // Two into queue 4, two into queue 5
         send(WRITE, RA_W'(16'h0200 + i), CA_W'(32 * i), DQ_W'(16'hA5A0 + i), READ, 1'b0);
      end
      idle(3, READ, 1'b1);                   // Writes wait in READ mode
      drain();
      end_test("write group");
   endtask

   task automatic test_open_burst();
      send(READ, 16'h0203, 10'h000, '0, READ, 1'b0);
      idle(1, READ, 1'b1);                   // Served, read pointer on queue 3
      send(WRITE, 16'h0102, 10'h030, 16'h1234, READ, 1'b0);
      send(READ, 16'h0500, 10'h010, '0, READ, 1'b0);
      send(READ, 16'h0102, 10'h035, '0, READ, 1'b0); // Same burst as the write
      send(READ, 16'h0501, 10'h010, '0, READ, 1'b0);
      idle(1, WRITE, 1'b1);                  // Write served, sets last burst
      cycle(1'b0, '0, READ, 1'b1);
      compare_bit("open-burst queue 2 served before queue 0", result_o.ra == 16'h0102, 1'b1);
      drain();
      end_test("open-burst priority");
   endtask

   task automatic test_full_queue();
      for (int i = 0; i < 5; i++) begin     // All land in queue 2, fifth stalls
         send(READ, RA_W'(16'h0302 + 16'h10 * i), CA_W'(16 * i), '0, READ, 1'b0);
      end
      drain();
      end_test("full queue");
   endtask

   task automatic test_random();
      req_t        r;
      logic [63:0] rnd;
      logic [31:0] bits;
      logic        mode;
      logic        ready;
      mode = READ;
      for (int i = 0; i < 200; i++) begin
         rnd  = {$random(seed), $random(seed)};
         bits = $random(seed);
         r    = rnd[$bits(req_t)-1:0];
         r.ra[RA_W-1:3] = '0;               // Small address space for burst hits
         r.ca[CA_W-1:6] = '0;
         r.idx = next_idx;
         next_idx++;
         if (i % 20 == 19) begin
            mode = ~mode;
         end
         ready = (bits[2:1] != 2'b00);      // Ready about three cycles in four
         cycle(bits[0], r, mode, ready);
         if (!ready) begin
            compare_bit("result_valid_o after ready_i low", result_valid_o, 1'b0);
         end
      end
      drain();
      end_test("back-pressure and random traffic");
   endtask

   initial begin
      seed        = 4;
      rst_n_i     = 1'b0;
      req_valid_i = 1'b0;
      req_i       = '0;
      mode_i      = READ;
      ready_i     = 1'b0;
      m_last      = '0;
      m_rr[WRITE] = Q_NUM - 1;               // Pointers start on each group's last queue
      m_rr[READ]  = RD_Q_NUM - 1;
      exp_valid   = 1'b0;
      next_idx    = '0;
      repeat (10) @(posedge clk);
      #2;
      rst_n_i = 1'b1;
      test_reset();
      test_read_order();
      test_write_group();
      test_open_burst();
      test_full_queue();
      test_random();
      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== testbench/bank_sched_assertions.sv ====
`timescale 1ns/1ps

module bank_sched_assertions (
   input logic                   clk,
   input logic                   rst_n_i,
   input logic                   mode_i,      // Controller mode
   input logic                   ready_i,     // Arbiter ready
   input bank_sched_pkg::q_vec_t empty_i,     // Queue empty flags
   input bank_sched_pkg::q_vec_t pop_o        // Pop vector from the scheduler
);

   import bank_sched_pkg::*;

   a_pop_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0(pop_o))
      else $error("pop_o has more than one bit set: %h", pop_o);

   a_no_pop_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
      !ready_i |-> (pop_o == '0))                     // Arbiter busy
      else $error("pop_o %h while ready_i low", pop_o);

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
      (pop_o & empty_i) == '0)
      else $error("pop_o %h hits empty queues %h", pop_o, empty_i);

   a_pop_group: assert property (@(posedge clk) disable iff (!rst_n_i)
      (pop_o & ((mode_i == READ) ? WR_GRP : RD_GRP)) == '0) // Only the mode's group
      else $error("pop_o %h outside group of mode %h", pop_o, mode_i);

endmodule

bind burst_sched bank_sched_assertions u_assert (.*);

// ==== hdl/bank_sched_top.sv ====
`timescale 1ns/1ps

module bank_sched_top (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic                   req_valid_i,     // Request strobe
   input  bank_sched_pkg::req_t   req_i,           // Request word for this bank
   input  logic                   mode_i,          // Controller mode level
   input  logic                   ready_i,         // Arbiter ready level
   output logic                   req_stall_o,     // Request dropped
   output logic                   result_valid_o,
   output bank_sched_pkg::entry_t result_o         // Served entry to the arbiter
);

   import bank_sched_pkg::*;

   q_vec_t                  push;                  // Decode to queues
   q_vec_t                  pop;                   // Scheduler to queues
   q_vec_t                  empty;
   q_vec_t                  full;
   entry_t                  entry;                 // Entry being pushed
   entry_t [Q_NUM-1:0]      head;                  // Head of every queue

   req_decode u_decode (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .req_valid_i  (req_valid_i),
      .req_i        (req_i),
      .full_i       (full),
      .push_o       (push),
      .entry_o      (entry),
      .req_stall_o  (req_stall_o)
   );

   bank_queues u_queues (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .push_i       (push),
      .pop_i        (pop),
      .entry_i      (entry),
      .empty_o      (empty),
      .full_o       (full),
      .head_o       (head)
   );

   burst_sched u_sched (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .mode_i         (mode_i),
      .ready_i        (ready_i),
      .empty_i        (empty),
      .head_i         (head),
      .pop_o          (pop),
      .result_valid_o (result_valid_o),
      .result_o       (result_o)
   );

endmodule

// ==== hdl/burst_sched.sv ====
`timescale 1ns/1ps

module burst_sched (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic                   mode_i,        // READ or WRITE controller mode
   input  logic                   ready_i,       // Arbiter can take a request
   input  bank_sched_pkg::q_vec_t empty_i,
   input  bank_sched_pkg::entry_t [bank_sched_pkg::Q_NUM-1:0] head_i,
   output bank_sched_pkg::q_vec_t pop_o,         // One-hot pop, or zero
   output logic                   result_valid_o,
   output bank_sched_pkg::entry_t result_o
);

   import bank_sched_pkg::*;

   q_vec_t               cand;                   // Poppable queues this cycle
   logic                 any;                    // A pop happens at this edge
   burst_t               last_burst;             // Burst of the last served entry
   logic [Q_IDX_W-1:0]   rr_rd;                  // Read group round-robin pointer
   logic [Q_IDX_W-1:0]   rr_wr;                  // Write group round-robin pointer
   logic [Q_IDX_W-1:0]   grp_ptr;
   logic [Q_IDX_W-1:0]   grp_base;               // First queue of the group
   int                   grp_num;                // Queues in the group
   logic [Q_IDX_W-1:0]   hit_q;                  // Lowest open-burst queue
   logic                 hit_found;
   logic [Q_IDX_W-1:0]   rr_q;                   // Round-robin choice
   logic [Q_IDX_W-1:0]   sel_q;                  // Queue served

   // Group of the current mode
   always_comb begin
      if (mode_i == WRITE) begin
         cand     = ~empty_i & WR_GRP;
         grp_ptr  = rr_wr;
         grp_base = Q_IDX_W'(RD_Q_NUM);
         grp_num  = WR_Q_NUM;
      end else begin
         cand     = ~empty_i & RD_GRP;
         grp_ptr  = rr_rd;
         grp_base = '0;
         grp_num  = RD_Q_NUM;
      end
      if (!ready_i) begin
         cand = '0;                              // Arbiter busy, nothing to pop
      end
   end

   assign any = |cand;

   // Open-burst hit, lowest index wins
   always_comb begin
      hit_q     = '0;
      hit_found = 1'b0;
      for (int q = 0; q < Q_NUM; q++) begin
         if (!hit_found && cand[q] && (burst_of(head_i[q]) == last_burst)) begin
            hit_q     = Q_IDX_W'(q);
            hit_found = 1'b1;
         end
      end
   end

   // First candidate after the pointer, wrapping inside the group
   always_comb begin
      int   idx_c;
      logic rr_found;
      idx_c    = 0;
      rr_found = 1'b0;
      rr_q     = grp_ptr;
      for (int i = 1; i <= RD_Q_NUM; i++) begin  // Read group is the larger one
         if (!rr_found && i <= grp_num) begin
            idx_c = int'(grp_base) + (int'(grp_ptr) - int'(grp_base) + i) % grp_num;
            if (cand[idx_c]) begin
               rr_q     = Q_IDX_W'(idx_c);
               rr_found = 1'b1;
            end
         end
      end
   end

   assign sel_q = hit_found ? hit_q : rr_q;
   assign pop_o = any ? (q_vec_t'(1) << sel_q) : '0;

   // Scheduler state and result valid
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         result_valid_o <= 1'b0;
         last_burst     <= '0;
         rr_rd          <= Q_IDX_W'(RD_Q_NUM - 1); // Start so queue 0 comes first
         rr_wr          <= Q_IDX_W'(Q_NUM - 1);
      end else begin
         result_valid_o <= any;
         if (any) begin
            last_burst <= burst_of(head_i[sel_q]);
            if (mode_i == WRITE) begin
               rr_wr <= sel_q;
            end else begin
               rr_rd <= sel_q;
            end
         end
      end
   end

   // Result register
   always_ff @(posedge clk) begin
      if (any) begin
         result_o <= head_i[sel_q];              // Popped entry, valid next cycle
      end
   end

endmodule

// ==== hdl/bank_queues.sv ====
`timescale 1ns/1ps

module bank_queues (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  bank_sched_pkg::q_vec_t push_i,        // One-hot push from decode
   input  bank_sched_pkg::q_vec_t pop_i,         // One-hot pop from scheduler
   input  bank_sched_pkg::entry_t entry_i,       // Entry to store
   output bank_sched_pkg::q_vec_t empty_o,
   output bank_sched_pkg::q_vec_t full_o,
   output bank_sched_pkg::entry_t [bank_sched_pkg::Q_NUM-1:0] head_o // Head of each queue
);

   import bank_sched_pkg::*;

   for (genvar q = 0; q < Q_NUM; q++) begin : g_q

      // Read queues are deeper than write queues
      localparam int DEPTH = (q < RD_Q_NUM) ? RD_Q_DEPTH : WR_Q_DEPTH;
      localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
      localparam int CNT_W = $clog2(DEPTH + 1);

      entry_t           mem [DEPTH];             // Circular storage
      logic [PTR_W-1:0] wr_ptr;                  // Next slot to write
      logic [PTR_W-1:0] rd_ptr;                  // Current head slot
      logic [CNT_W-1:0] count;                   // Entries held
      logic             do_push;
      logic             do_pop;

      assign do_push = push_i[q] && !full_o[q];  // Ignore push into a full queue
      assign do_pop  = pop_i[q] && !empty_o[q];  // Ignore pop of an empty queue

      assign empty_o[q] = (count == '0);
      assign full_o[q]  = (count == CNT_W'(DEPTH));
      assign head_o[q]  = mem[rd_ptr];           // Head always visible

      // Pointers and fill count
      always_ff @(posedge clk) begin
         if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
         end else begin
            if (do_push) begin
               wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
               rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
               2'b10:   count <= count + 1'b1;
               2'b01:   count <= count - 1'b1;
               default: count <= count;          // Both or neither, level unchanged
            endcase
         end
      end

      // Payload write
      always_ff @(posedge clk) begin
         if (do_push) begin
            mem[wr_ptr] <= entry_i;
         end
      end

   end

endmodule

// ==== hdl/req_decode.sv ====
`timescale 1ns/1ps

module req_decode (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic                   req_valid_i,   // Request strobe from transaction controller
   input  bank_sched_pkg::req_t   req_i,
   input  bank_sched_pkg::q_vec_t full_i,        // Queue full flags
   output bank_sched_pkg::q_vec_t push_o,        // One-hot push into the queues
   output bank_sched_pkg::entry_t entry_o,       // Entry written on push
   output logic                   req_stall_o    // Request dropped this cycle
);

   import bank_sched_pkg::*;

   q_vec_t target;                               // Queue chosen for this request
   logic   room;                                 // Target queue can take it

   // Queue selection
   always_comb begin
      target = '0;
      room   = 1'b0;
      if (req_i.req_type == READ) begin
         target[req_i.ra[1:0]] = 1'b1;           // Low row bits pick the read queue
         room = !full_i[req_i.ra[1:0]];
      end else begin
         for (int q = RD_Q_NUM; q < Q_NUM; q++) begin
            if (!room && !full_i[q]) begin       // Lowest write queue with space
               target[q] = 1'b1;
               room      = 1'b1;
            end
         end
      end
   end

   // Push or stall
   always_comb begin
      push_o      = '0;
      req_stall_o = 1'b0;
      if (req_valid_i) begin
         if (room) begin
            push_o = target;
         end else begin
            req_stall_o = 1'b1;                  // Dropped, upstream must resend
         end
      end
   end

   // Field reorder into the stored layout
   assign entry_o.idx      = req_i.idx;
   assign entry_o.ra       = req_i.ra;
   assign entry_o.ca       = req_i.ca;
   assign entry_o.dq       = req_i.dq;
   assign entry_o.req_type = req_i.req_type;

endmodule

// ==== hdl/bank_sched_pkg.sv ====
package bank_sched_pkg;

   // Request field widths
   localparam int RA_W    = 16;                 // Row address
   localparam int CA_W    = 10;                 // Column address
   localparam int IDX_W   = 7;                  // Transaction index
   localparam int DQ_W    = 16;                 // Write data
   localparam int BURST_W = RA_W + CA_W - 4;    // Row plus upper six column bits

   // Queue organisation
   localparam int RD_Q_NUM   = 4;                     // Queues 0..3
   localparam int WR_Q_NUM   = 3;                     // Queues 4..6
   localparam int Q_NUM      = RD_Q_NUM + WR_Q_NUM;
   localparam int Q_IDX_W    = $clog2(Q_NUM);         // Width of a queue number
   localparam int RD_Q_DEPTH = 4;
   localparam int WR_Q_DEPTH = 2;

   localparam logic READ  = 1'b1;               // Type bit and controller mode
   localparam logic WRITE = 1'b0;

   typedef logic [Q_NUM-1:0]   q_vec_t;         // One bit per queue
   typedef logic [BURST_W-1:0] burst_t;

   localparam q_vec_t RD_GRP = q_vec_t'((1 << RD_Q_NUM) - 1); // Read group mask
   localparam q_vec_t WR_GRP = ~RD_GRP;                        // Write group mask

   // Incoming request word, 50 bits
   typedef struct packed {
      logic             req_type;               // READ or WRITE
      logic [IDX_W-1:0] idx;
      logic [RA_W-1:0]  ra;
      logic [CA_W-1:0]  ca;
      logic [DQ_W-1:0]  dq;
   } req_t;

   // Stored queue entry
   typedef struct packed {
      logic [IDX_W-1:0] idx;
      logic [RA_W-1:0]  ra;
      logic [CA_W-1:0]  ca;
      logic [DQ_W-1:0]  dq;                     // Don't care for reads
      logic             req_type;
   } entry_t;

   // Burst address of an entry, row plus column without the beat bits
   function automatic burst_t burst_of(entry_t e);
      return {e.ra, e.ca[CA_W-1:4]};
   endfunction

endpackage
